// ==== files.f ====
verilog/lfmr_alu_pkg.sv
verilog/chunk_carry_adder.sv
verilog/chunk_reducer.sv
verilog/chunk_comparator.sv
verilog/lfmr_alu.sv
tb/tb_lfmr_alu.sv

// ==== tb/tb_lfmr_alu.sv ====
// testbench for the chunked ALU, directed and LFSR driven cases
// checks every output against a model built from the operand rules

`timescale 1ns/100ps

module tb_lfmr_alu
    import lfmr_alu_pkg::*;
();

    localparam int WIDTH          = 16;
    localparam int LATENCY        = 4;
    // one spare cycle on top of the settle time
    localparam int SETTLE         = LATENCY + 1;
    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_CASES   = 200;
    // about 230 settle windows plus reset, with margin
    localparam int TIMEOUT_CYCLES = 2500;

    logic             clk;
    logic             rst;
    logic [WIDTH-1:0] i1;
    logic [WIDTH-1:0] i2;
    logic [WIDTH-1:0] i3;
    logic [WIDTH-1:0] sum;
    logic [WIDTH-1:0] sub;
    reduce_flags_t    flags;
    cmp_flags_t       cmp;

    logic [15:0] lfsr_state;
    int          cycle_count;
    int          test_count;
    int          failed_tests;
    int          check_count;
    int          error_count;
    int          test_err_start;

    lfmr_alu #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) lfmr_alu_i (
        .clk   (clk),
        .rst   (rst),
        .i1    (i1),
        .i2    (i2),
        .i3    (i3),
        .sum   (sum),
        .sub   (sub),
        .flags (flags),
        .cmp   (cmp)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // guard against a stuck run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1, shifts in the feedback bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [15:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_err_start = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count > test_err_start) begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, error_count - test_err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // new operands take effect on a rising edge
    task automatic apply_operands(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                  input logic [WIDTH-1:0] c);
        @(posedge clk);
        i1 <= a;
        i2 <= b;
        i3 <= c;
    endtask

    // wait out the settle window and sample on the falling edge
    task automatic settle_and_check();
        logic [WIDTH-1:0] exp_sum;
        logic [WIDTH-1:0] exp_sub;
        reduce_flags_t    exp_flags;
        cmp_flags_t       exp_cmp;
        repeat (SETTLE) @(posedge clk);
        @(negedge clk);
        // arithmetic wraps modulo 2**WIDTH
        exp_sum           = i1 + i2;
        exp_sub           = i1 - i2;
        exp_flags.red_and = &i1;
        exp_flags.red_or  = |i1;
        exp_flags.red_xor = ^i1;
        exp_cmp.eq        = (i1 == i3);
        exp_cmp.neq       = (i1 != i3);
        compare_value("sum", sum, exp_sum);
        compare_value("sub", sub, exp_sub);
        compare_value("red_and", flags.red_and, exp_flags.red_and);
        compare_value("red_or", flags.red_or, exp_flags.red_or);
        compare_value("red_xor", flags.red_xor, exp_flags.red_xor);
        compare_value("eq", cmp.eq, exp_cmp.eq);
        compare_value("neq", cmp.neq, exp_cmp.neq);
    endtask

    task automatic run_case(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                            input logic [WIDTH-1:0] c);
        apply_operands(a, b, c);
        settle_and_check();
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    // zero operands under reset, then the first edge after release
    task automatic test_reset();
        begin_test();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare_value("sum", sum, 16'h0000);
        compare_value("sub", sub, 16'h0000);
        compare_value("flags", flags, 3'b000);
        compare_value("cmp", cmp, 2'b00);
        @(posedge clk);
        rst <= 1'b0;
        // compare stage 2 stays at zero on the first edge with rst low
        @(posedge clk);
        @(negedge clk);
        compare_value("cmp", cmp, 2'b00);
        end_test("reset");
    endtask

    // carry and borrow ripple through every chunk boundary
    task automatic test_carry_chain();
        begin_test();
        run_case(16'hFFFF, 16'h0001, 16'h0000);
        run_case(16'h0000, 16'h0001, 16'h0000);
        run_case(16'h0FFF, 16'h0001, 16'h0FFF);
        run_case(16'h1000, 16'h0001, 16'h1000);
        end_test("carry_chain");
    endtask

    task automatic test_reductions();
        begin_test();
        run_case(16'hFFFF, 16'h0000, 16'h0000);
        run_case(16'h0000, 16'h0000, 16'h0000);
        // lone bit in the top chunk
        run_case(16'h8000, 16'h0000, 16'h0000);
        // alternating, even parity
        run_case(16'h5555, 16'h0000, 16'h0000);
        run_case(16'hAAAA, 16'h0000, 16'h0000);
        // alternating, odd parity
        run_case(16'h2AAA, 16'h0000, 16'h0000);
        end_test("reductions");
    endtask

    task automatic test_compare();
        begin_test();
        run_case(16'hA5C3, 16'h0000, 16'hA5C3);
        // differ only in the lowest chunk
        run_case(16'h1234, 16'h0000, 16'h1235);
        // differ only in the highest chunk
        run_case(16'h1234, 16'h0000, 16'h9234);
        end_test("compare");
    endtask

    task automatic test_random();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] same;
        begin_test();
        for (int n = 0; n < RANDOM_CASES; n++) begin
            draw_bits(16, a);
            draw_bits(16, b);
            draw_bits(16, c);
            // about half the cases force i3 equal to i1 so eq gets exercised
            draw_bits(1, same);
            if (same[0]) begin
                c = a;
            end
            run_case(a, b, c);
        end
        end_test("random");
    endtask

    // operands move on three edges in a row, only the last ones count
    task automatic test_restart();
        begin_test();
        apply_operands(16'h1111, 16'h2222, 16'h3333);
        apply_operands(16'hFFFF, 16'h0001, 16'hFFFF);
        apply_operands(16'h0F0F, 16'h00F1, 16'h0F0F);
        settle_and_check();
        end_test("restart");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        i1           = '0;
        i2           = '0;
        i3           = '0;
        lfsr_state   = 16'd42736;
        cycle_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        check_count  = 0;
        error_count  = 0;

        test_reset();
        test_carry_chain();
        test_reductions();
        test_compare();
        test_random();
        test_restart();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/chunk_carry_adder.sv ====
// chunked adder or subtractor, carry or borrow between chunks held in registers
// one chunk settles per clock edge

`timescale 1ns/100ps

module chunk_carry_adder
    import lfmr_alu_pkg::*;
#(
    parameter int WIDTH    = 16,
    parameter int LATENCY  = 4,
    // 0 gives a + b, 1 gives a - b
    parameter bit SUBTRACT = 1'b0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] result
);

    localparam int CHUNK_W     = alu_chunk_width(WIDTH, LATENCY);
    localparam int CHUNK_COUNT = alu_chunk_count(WIDTH, LATENCY);
    localparam int LAST_W      = alu_last_chunk_size(WIDTH, LATENCY);
    // carry out of the top chunk is never stored
    // keep at least one bit so a single chunk still builds
    localparam int CARRY_W     = (CHUNK_COUNT > 1) ? CHUNK_COUNT - 1 : 1;

    typedef logic [CARRY_W-1:0] carry_vec_t;

    // carry_next is combinational, carry_q feeds the chunk above on the next edge
    carry_vec_t carry_q;
    carry_vec_t carry_next;

    //////////////////////////////////////////////////////////////////////
    // per chunk arithmetic
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < CHUNK_COUNT; k++) begin : g_chunk
        localparam int LO = k * CHUNK_W;
        // top chunk may be narrower
        localparam int SZ = (k == CHUNK_COUNT - 1) ? LAST_W : CHUNK_W;

        logic          carry_in;
        // one extra bit on top holds the carry or borrow out
        logic [SZ:0]   chunk_full;

        // chunk 0 starts the chain with no carry
        if (k == 0) begin : g_first
            assign carry_in = 1'b0;
        end else begin : g_chained
            assign carry_in = carry_q[k-1];
        end

        if (SUBTRACT) begin : g_sub
            // top bit set means this chunk borrowed from the one above
            assign chunk_full = {1'b0, a[LO +: SZ]} - {1'b0, b[LO +: SZ]} - carry_in;
        end else begin : g_add
            assign chunk_full = {1'b0, a[LO +: SZ]} + {1'b0, b[LO +: SZ]} + carry_in;
        end

        assign result[LO +: SZ] = chunk_full[SZ-1:0];

        // top chunk wraps modulo 2**WIDTH so its carry out goes nowhere
        if (k < CHUNK_COUNT - 1) begin : g_carry_out
            assign carry_next[k] = chunk_full[SZ];
        end
    end

    // with a single chunk there is no chain to carry
    if (CHUNK_COUNT == 1) begin : g_no_chain
        assign carry_next = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // carry registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            carry_q <= '0;
        end else begin
            carry_q <= carry_next;
        end
    end

    // the chain must stay known once out of reset, or every chunk above goes X
    carry_known_a: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(carry_q)
    ) else $error("chunk_carry_adder: carry register holds unknown bits");

endmodule

// ==== verilog/chunk_comparator.sv ====
// two stage registered equality and inequality of a against b
// eq and neq each come straight from a register

`timescale 1ns/100ps

module chunk_comparator
    import lfmr_alu_pkg::*;
#(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output cmp_flags_t       cmp
);

    localparam int CHUNK_W     = alu_chunk_width(WIDTH, LATENCY);
    localparam int CHUNK_COUNT = alu_chunk_count(WIDTH, LATENCY);
    localparam int LAST_W      = alu_last_chunk_size(WIDTH, LATENCY);

    typedef logic [CHUNK_COUNT-1:0] chunk_vec_t;

    chunk_vec_t chunk_eq_d;
    chunk_vec_t chunk_eq_q;
    // set once stage 1 holds real compare results
    logic       primed_q;
    logic       eq_q;
    logic       neq_q;

    //////////////////////////////////////////////////////////////////////
    // stage 1, compare each chunk
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < CHUNK_COUNT; k++) begin : g_chunk
        localparam int LO = k * CHUNK_W;
        localparam int SZ = (k == CHUNK_COUNT - 1) ? LAST_W : CHUNK_W;

        assign chunk_eq_d[k] = (a[LO +: SZ] == b[LO +: SZ]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chunk_eq_q <= '0;
            primed_q   <= 1'b0;
        end else begin
            chunk_eq_q <= chunk_eq_d;
            primed_q   <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, AND of chunk results, NAND in a second register
    //////////////////////////////////////////////////////////////////////

    // both bits stay low until stage 1 has loaded once after reset
    // otherwise the reset zeros in stage 1 would read as a mismatch
    always_ff @(posedge clk) begin
        if (rst) begin
            eq_q  <= 1'b0;
            neq_q <= 1'b0;
        end else begin
            eq_q  <= primed_q & (&chunk_eq_q);
            // separate flop keeps the inverter off the output path
            neq_q <= primed_q & ~(&chunk_eq_q);
        end
    end

    assign cmp.eq  = eq_q;
    assign cmp.neq = neq_q;

    eq_neq_exclusive_a: assert property (
        @(posedge clk) !(eq_q && neq_q)
    ) else $error("chunk_comparator: eq and neq both set");

endmodule

// ==== verilog/chunk_reducer.sv ====
// two stage registered AND, OR and XOR reduction of one operand
// chunk stage first, then the combine stage

`timescale 1ns/100ps

module chunk_reducer
    import lfmr_alu_pkg::*;
#(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] operand,
    output reduce_flags_t    flags
);

    localparam int CHUNK_W     = alu_chunk_width(WIDTH, LATENCY);
    localparam int CHUNK_COUNT = alu_chunk_count(WIDTH, LATENCY);
    localparam int LAST_W      = alu_last_chunk_size(WIDTH, LATENCY);

    // one bit per chunk
    typedef logic [CHUNK_COUNT-1:0] chunk_vec_t;

    chunk_vec_t    chunk_and_d;
    chunk_vec_t    chunk_or_d;
    chunk_vec_t    chunk_xor_d;
    chunk_vec_t    chunk_and_q;
    chunk_vec_t    chunk_or_q;
    chunk_vec_t    chunk_xor_q;
    reduce_flags_t flags_q;

    //////////////////////////////////////////////////////////////////////
    // stage 1, reduce each chunk
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < CHUNK_COUNT; k++) begin : g_chunk
        localparam int LO = k * CHUNK_W;
        localparam int SZ = (k == CHUNK_COUNT - 1) ? LAST_W : CHUNK_W;

        assign chunk_and_d[k] = &operand[LO +: SZ];
        assign chunk_or_d[k]  = |operand[LO +: SZ];
        assign chunk_xor_d[k] = ^operand[LO +: SZ];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chunk_and_q <= '0;
            chunk_or_q  <= '0;
            chunk_xor_q <= '0;
        end else begin
            chunk_and_q <= chunk_and_d;
            chunk_or_q  <= chunk_or_d;
            chunk_xor_q <= chunk_xor_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, combine each column across chunks
    //////////////////////////////////////////////////////////////////////

    // stage 1 is all zero right after reset, so the first edge still gives 0 flags
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else begin
            flags_q.red_and <= &chunk_and_q;
            flags_q.red_or  <= |chunk_or_q;
            flags_q.red_xor <= ^chunk_xor_q;
        end
    end

    assign flags = flags_q;

    // both columns come from the same stage 1 snapshot
    // so all ones can never show up with no bit set
    and_implies_or_a: assert property (
        @(posedge clk) flags_q.red_and |-> flags_q.red_or
    ) else $error("chunk_reducer: red_and set while red_or is clear");

endmodule

// ==== verilog/lfmr_alu.sv ====
// top level of the chunked multi-cycle ALU
// sum, difference, reductions of i1 and compare of i1 with i3

`timescale 1ns/100ps

module lfmr_alu
    import lfmr_alu_pkg::*;
#(
    parameter int WIDTH   = 16,
    // settle cycles, at least 2 for the two stage reduce and compare
    parameter int LATENCY = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] i1,
    input  logic [WIDTH-1:0] i2,
    input  logic [WIDTH-1:0] i3,
    output logic [WIDTH-1:0] sum,
    output logic [WIDTH-1:0] sub,
    output reduce_flags_t    flags,
    output cmp_flags_t       cmp
);

    //////////////////////////////////////////////////////////////////////
    // elaboration checks
    //////////////////////////////////////////////////////////////////////

    if (LATENCY < 2) begin : g_latency_check
        $error("lfmr_alu: LATENCY must be at least 2");
    end

    //////////////////////////////////////////////////////////////////////
    // units, each drives one result
    //////////////////////////////////////////////////////////////////////

    // i1 + i2
    chunk_carry_adder #(
        .WIDTH    (WIDTH),
        .LATENCY  (LATENCY),
        .SUBTRACT (1'b0)
    ) add_i (
        .clk    (clk),
        .rst    (rst),
        .a      (i1),
        .b      (i2),
        .result (sum)
    );

    // i1 - i2
    chunk_carry_adder #(
        .WIDTH    (WIDTH),
        .LATENCY  (LATENCY),
        .SUBTRACT (1'b1)
    ) sub_i (
        .clk    (clk),
        .rst    (rst),
        .a      (i1),
        .b      (i2),
        .result (sub)
    );

    chunk_reducer #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) reduce_i (
        .clk     (clk),
        .rst     (rst),
        .operand (i1),
        .flags   (flags)
    );

    // i1 against i3
    chunk_comparator #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) compare_i (
        .clk (clk),
        .rst (rst),
        .a   (i1),
        .b   (i3),
        .cmp (cmp)
    );

endmodule

// ==== verilog/lfmr_alu_pkg.sv ====
// chunk geometry functions and result flag structs
// shared by the chunked ALU and its units

package lfmr_alu_pkg;

    //////////////////////////////////////////////////////////////////////
    // chunk geometry
    //////////////////////////////////////////////////////////////////////

    // bits per chunk, one chunk settles per clock
    // a latency of 0 is treated as 1 to avoid a divide by zero
    function automatic int alu_chunk_width(int width, int latency);
        int denom;
        denom = (latency == 0) ? 1 : latency;
        // ceiling division so that no bit is left over
        return (width + denom - 1) / denom;
    endfunction

    // number of chunks needed to cover the whole operand
    function automatic int alu_chunk_count(int width, int latency);
        int chunk_w;
        chunk_w = alu_chunk_width(width, latency);
        return (width + chunk_w - 1) / chunk_w;
    endfunction

    // width of the top chunk
    // equals the chunk width unless the operand does not divide evenly
    function automatic int alu_last_chunk_size(int width, int latency);
        int chunk_w;
        int rem;
        chunk_w = alu_chunk_width(width, latency);
        rem = width % chunk_w;
        return (rem == 0) ? chunk_w : rem;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // result flags
    //////////////////////////////////////////////////////////////////////

    // reductions of operand i1
    typedef struct packed {
        // all bits set
        logic red_and;
        // any bit set
        logic red_or;
        // odd parity
        logic red_xor;
    } reduce_flags_t;

    // compare of i1 against i3
    // neq comes from its own register, not from inverting eq
    typedef struct packed {
        logic eq;
        logic neq;
    } cmp_flags_t;

endpackage
